// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_ext_mem
BUILD     ?= obj_dir
FILELIST  ?= sources.f
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SIM := $(BUILD)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(shell grep -v '^+' $(FILELIST)) ext_mem_cfg.svh
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: compile
	./$(SIM) 2>&1 | tee $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG) && echo "Simulation result: pass" || \
		(echo "Simulation result: fail"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== bus_merge.sv ====
`timescale 1ns/1ps

module bus_merge (
   input  logic      clk_i,
   input  logic      arst_i,
   mem_bus_if.slave  m0,  // Data cache, high priority
   mem_bus_if.slave  m1,  // Instruction cache
   mem_bus_if.master s
);

   logic busy_q;   // Transfer open on the slave
   logic owner_q;  // Granted master, 1 is m1
   logic sel;

   // Held grant while busy, else m0 wins any tie
   assign sel = busy_q ? owner_q : ~m0.req;

   // Combinational pass-through, no added cycles
   assign s.req   = sel ? m1.req   : m0.req;
   assign s.addr  = sel ? m1.addr  : m0.addr;
   assign s.wdata = sel ? m1.wdata : m0.wdata;
   assign s.wstrb = sel ? m1.wstrb : m0.wstrb;

   // Response goes only to the owner
   assign m0.ack   = s.ack & ~sel;
   assign m1.ack   = s.ack & sel;
   assign m0.rdata = sel ? '0 : s.rdata;
   assign m1.rdata = sel ? s.rdata : '0;

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         busy_q  <= 1'b0;
         owner_q <= 1'b0;
      end else if (s.ack) begin
         busy_q <= 1'b0;  // Release on slave ack
      end else if (!busy_q && s.req) begin
         busy_q  <= 1'b1;
         owner_q <= sel;
      end
   end

endmodule

// ==== ext_mem.sv ====
`timescale 1ns/1ps
`include "ext_mem_cfg.svh"

module ext_mem
   import ext_mem_pkg::*;
(
   input  logic  clk_i,
   input  logic  arst_i,

   // Instruction fetch, read only
   input  logic  i_req_i,
   input  addr_t i_addr_i,
   output data_t i_rdata_o,
   output logic  i_ack_o,

   // Data access
   input  logic  d_req_i,
   input  addr_t d_addr_i,
   input  data_t d_wdata_i,
   input  strb_t d_wstrb_i,
   output data_t d_rdata_o,
   output logic  d_ack_o,

   input  logic  inval_i,  // Data cache and L2 invalidate

   // Memory port
   output logic  mem_req_o,
   output addr_t mem_addr_o,
   output data_t mem_wdata_o,
   output strb_t mem_wstrb_o,
   input  data_t mem_rdata_i,
   input  logic  mem_ack_i
);

   mem_bus_if ic_fe ();
   mem_bus_if dc_fe ();
   mem_bus_if ic_be ();
   mem_bus_if dc_be ();
   mem_bus_if l2_fe ();
   mem_bus_if l2_be ();

   logic dc_inval;  // Dcache clear, forwarded to L2

   assign ic_fe.req   = i_req_i;
   assign ic_fe.addr  = i_addr_i;
   assign ic_fe.wdata = '0;
   assign ic_fe.wstrb = '0;  // Fetches never write
   assign i_rdata_o   = ic_fe.rdata;
   assign i_ack_o     = ic_fe.ack;

   assign dc_fe.req   = d_req_i;
   assign dc_fe.addr  = d_addr_i;
   assign dc_fe.wdata = d_wdata_i;
   assign dc_fe.wstrb = d_wstrb_i;
   assign d_rdata_o   = dc_fe.rdata;
   assign d_ack_o     = dc_fe.ack;

   assign mem_req_o   = l2_be.req;
   assign mem_addr_o  = l2_be.addr;
   assign mem_wdata_o = l2_be.wdata;
   assign mem_wstrb_o = l2_be.wstrb;
   assign l2_be.rdata = mem_rdata_i;
   assign l2_be.ack   = mem_ack_i;

   mem_cache #(.LINES_W(`EXT_MEM_L1_LINES_W)) u_icache (
      .clk_i   (clk_i),
      .arst_i  (arst_i),
      .fe      (ic_fe),
      .be      (ic_be),
      .inval_i (1'b0),
      .inval_o ()
   );

   mem_cache #(.LINES_W(`EXT_MEM_L1_LINES_W)) u_dcache (
      .clk_i   (clk_i),
      .arst_i  (arst_i),
      .fe      (dc_fe),
      .be      (dc_be),
      .inval_i (inval_i),
      .inval_o (dc_inval)
   );

   bus_merge u_merge (
      .clk_i  (clk_i),
      .arst_i (arst_i),
      .m0     (dc_be),
      .m1     (ic_be),
      .s      (l2_fe)
   );

   mem_cache #(.LINES_W(`EXT_MEM_L2_LINES_W)) u_l2 (
      .clk_i   (clk_i),
      .arst_i  (arst_i),
      .fe      (l2_fe),
      .be      (l2_be),
      .inval_i (dc_inval),
      .inval_o ()
   );

endmodule

// ==== ext_mem_cfg.svh ====
`ifndef EXT_MEM_CFG_SVH
`define EXT_MEM_CFG_SVH

// Byte address width of every bus in the subsystem
`define EXT_MEM_ADDR_W 16

// Data word width, one word per cache line
`define EXT_MEM_DATA_W 32

// Log2 of the line count of each first-level cache
`define EXT_MEM_L1_LINES_W 5

// Log2 of the line count of the shared L2
`define EXT_MEM_L2_LINES_W 7

`endif

// ==== ext_mem_pkg.sv ====
`include "ext_mem_cfg.svh"

package ext_mem_pkg;

   // Byte address, bits [1:0] unused
   typedef logic [`EXT_MEM_ADDR_W-1:0] addr_t;

   typedef logic [`EXT_MEM_DATA_W-1:0] data_t;

   // Zero strobe means read
   typedef logic [`EXT_MEM_DATA_W/8-1:0] strb_t;

   // Cache controller states
   typedef enum logic [1:0] {
      C_IDLE,  // Waiting for a request
      C_HIT,   // Front ack, also after fill and write
      C_FILL,  // Read miss, back end busy
      C_WRITE  // Write-through in progress
   } cache_state_t;

endpackage

// ==== ext_mem_sva.sv ====
`timescale 1ns/1ps

module ext_mem_sva
   import ext_mem_pkg::*;
(
   input logic  clk_i,
   input logic  arst_i,
   input logic  i_req_i,
   input addr_t i_addr_i,
   input logic  i_ack_o,
   input logic  d_req_i,
   input addr_t d_addr_i,
   input data_t d_wdata_i,
   input strb_t d_wstrb_i,
   input logic  d_ack_o,
   input logic  mem_req_o,
   input addr_t mem_addr_o,
   input data_t mem_wdata_o,
   input strb_t mem_wstrb_o,
   input logic  mem_ack_i
);

   int fail_cnt = 0;  // Failed assertion count

   // Requests hold until acked
   a_i_stable: assert property (@(posedge clk_i) disable iff (arst_i)
      i_req_i && !i_ack_o |=> i_req_i && $stable(i_addr_i))
      else begin
         $error("instruction request changed before ack");
         fail_cnt++;
      end
   a_d_stable: assert property (@(posedge clk_i) disable iff (arst_i)
      d_req_i && !d_ack_o |=> d_req_i && $stable(d_addr_i) && $stable(d_wdata_i)
                              && $stable(d_wstrb_i))
      else begin
         $error("data request changed before ack");
         fail_cnt++;
      end
   a_mem_stable: assert property (@(posedge clk_i) disable iff (arst_i)
      mem_req_o && !mem_ack_i |=> mem_req_o && $stable(mem_addr_o)
                                  && $stable(mem_wdata_o) && $stable(mem_wstrb_o))
      else begin
         $error("memory request changed before ack");
         fail_cnt++;
      end

   a_i_ack: assert property (@(posedge clk_i) disable iff (arst_i) i_ack_o |-> i_req_i)
      else begin
         $error("instruction ack without request");
         fail_cnt++;
      end
   a_d_ack: assert property (@(posedge clk_i) disable iff (arst_i) d_ack_o |-> d_req_i)
      else begin
         $error("data ack without request");
         fail_cnt++;
      end
   a_mem_ack: assert property (@(posedge clk_i) disable iff (arst_i) mem_ack_i |-> mem_req_o)
      else begin
         $error("memory ack without request");
         fail_cnt++;
      end

   a_rst: assert property (@(posedge clk_i) arst_i |-> !mem_req_o)
      else begin
         $error("memory request during reset");
         fail_cnt++;
      end

endmodule

bind ext_mem ext_mem_sva u_sva (.*);

// ==== mem_bus_if.sv ====
`timescale 1ns/1ps

interface mem_bus_if
   import ext_mem_pkg::*;
();
   logic  req;    // Held until ack
   addr_t addr;
   data_t wdata;
   strb_t wstrb;  // Any set bit makes it a write
   data_t rdata;  // Valid with ack on reads
   logic  ack;    // One-cycle pulse

   modport master (
      output req,
      output addr,
      output wdata,
      output wstrb,
      input  rdata,
      input  ack
   );

   modport slave (
      input  req,
      input  addr,
      input  wdata,
      input  wstrb,
      output rdata,
      output ack
   );

endinterface

// ==== mem_cache.sv ====
`timescale 1ns/1ps
`include "ext_mem_cfg.svh"

module mem_cache
   import ext_mem_pkg::*;
#(
   parameter int LINES_W = `EXT_MEM_L1_LINES_W
) (
   input  logic      clk_i,
   input  logic      arst_i,
   mem_bus_if.slave  fe,
   mem_bus_if.master be,
   input  logic      inval_i,
   output logic      inval_o
);

   localparam int LINES = 1 << LINES_W;
   localparam int TAG_W = `EXT_MEM_ADDR_W - LINES_W - 2;

   typedef logic [LINES_W-1:0] idx_t;
   typedef logic [TAG_W-1:0]   tag_t;

   tag_t             tag_mem  [LINES];
   data_t            data_mem [LINES];
   logic [LINES-1:0] valid_q;

   cache_state_t state_q;
   cache_state_t state_d;
   logic         inval_pend_q;

   idx_t idx;
   tag_t tag;
   logic is_write;
   logic tag_match;
   logic stale;
   logic hit;
   logic clear;
   logic fill_done;
   logic write_done;

   assign idx = fe.addr[LINES_W+1:2];                   // Word address bits
   assign tag = fe.addr[`EXT_MEM_ADDR_W-1:LINES_W+2];
   assign is_write = |fe.wstrb;

   assign tag_match = valid_q[idx] && (tag_mem[idx] == tag);

   // Lines may be stale until the pending clear is done, so treat as miss
   assign stale = inval_pend_q | inval_i;
   assign hit   = tag_match & ~stale;

   // Clear only between requests, never under one in flight
   assign clear   = inval_pend_q && (state_q == C_IDLE) && !fe.req;
   assign inval_o = clear;

   assign fill_done  = (state_q == C_FILL) && be.ack;
   assign write_done = (state_q == C_WRITE) && be.ack;

   always_comb begin
      state_d = state_q;
      case (state_q)
         C_IDLE: begin
            if (fe.req) begin
               if (is_write) begin
                  state_d = C_WRITE;
               end else if (hit) begin
                  state_d = C_HIT;
               end else begin
                  state_d = C_FILL;
               end
            end
         end
         C_FILL, C_WRITE: begin
            if (be.ack) begin
               state_d = C_HIT;  // Reply one clock after back-end ack
            end
         end
         C_HIT: state_d = C_IDLE;
         default: state_d = C_IDLE;
      endcase
   end

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         state_q      <= C_IDLE;
         inval_pend_q <= 1'b0;
         valid_q      <= '0;
      end else begin
         state_q      <= state_d;
         inval_pend_q <= inval_i | (inval_pend_q & ~clear);
         if (clear) begin
            valid_q <= '0;
         end else if (fill_done) begin
            valid_q[idx] <= 1'b1;
         end
      end
   end

   // Line storage
   always_ff @(posedge clk_i) begin
      if (fill_done) begin
         tag_mem[idx]  <= tag;
         data_mem[idx] <= be.rdata;
      end else if (write_done && tag_match) begin
         // Write hit, merge strobed bytes, no allocate on miss
         for (int b = 0; b < $bits(strb_t); b++) begin
            if (fe.wstrb[b]) begin
               data_mem[idx][8*b +: 8] <= fe.wdata[8*b +: 8];
            end
         end
      end
   end

   assign fe.ack   = (state_q == C_HIT);
   assign fe.rdata = data_mem[idx];  // Freshly filled word after a miss

   // Back end reuses the held front request
   assign be.req   = (state_q == C_FILL) || (state_q == C_WRITE);
   assign be.addr  = fe.addr;
   assign be.wdata = fe.wdata;
   assign be.wstrb = (state_q == C_WRITE) ? fe.wstrb : '0;  // Fill is a read

endmodule

// ==== sources.f ====
+incdir+.
ext_mem_pkg.sv
mem_bus_if.sv
mem_cache.sv
bus_merge.sv
ext_mem.sv
ext_mem_sva.sv
tb_ext_mem.sv

// ==== tb_ext_mem.sv ====
`timescale 1ns/1ps
`include "ext_mem_cfg.svh"

module tb_ext_mem
   import ext_mem_pkg::*;
();

   localparam int     WORDS    = 1 << (`EXT_MEM_ADDR_W - 2);
   localparam int     N_OPS    = 300;   // Per front port
   localparam realtime PERIOD  = 40.0;
   localparam realtime TIMEOUT = (2 * N_OPS) * 40 * PERIOD + 20 * PERIOD;

   logic  clk_i = 1'b0;
   logic  arst_i;
   logic  i_req_i;
   addr_t i_addr_i;
   data_t i_rdata_o;
   logic  i_ack_o;
   logic  d_req_i;
   addr_t d_addr_i;
   data_t d_wdata_i;
   strb_t d_wstrb_i;
   data_t d_rdata_o;
   logic  d_ack_o;
   logic  inval_i;
   logic  mem_req_o;
   addr_t mem_addr_o;
   data_t mem_wdata_o;
   strb_t mem_wstrb_o;
   data_t mem_rdata_i;
   logic  mem_ack_i;

   data_t mem_q    [WORDS];  // Memory behind the port
   data_t ref_mem  [WORDS];  // Expected contents
   int    rd_count [WORDS];  // Memory reads per word

   // Memory port writes in arrival order
   addr_t wr_addr_q [$];
   data_t wr_data_q [$];
   strb_t wr_strb_q [$];

   logic [15:0] lfsr_q = 16'd19199;

   always #20 clk_i = ~clk_i;

   ext_mem ext_mem_i (.*);

   function automatic logic next_bit();
      logic b;
      b = lfsr_q[0];
      lfsr_q = lfsr_q >> 1;
      if (b) begin
         lfsr_q = lfsr_q ^ 16'hB400;  // Galois taps 16,14,13,11
      end
      return b;
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int k = 0; k < n; k++) begin
         r = {r[30:0], next_bit()};
      end
      return r;
   endfunction

   function automatic data_t merge_bytes(input data_t old, input data_t wd, input strb_t s);
      data_t r;
      r = old;
      for (int b = 0; b < 4; b++) begin
         if (s[b]) begin
            r[8*b +: 8] = wd[8*b +: 8];
         end
      end
      return r;
   endfunction

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         $display("** Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
         $display("TESTBENCH FAILED");
         $fatal(1, "value mismatch");
      end
   endtask

   task automatic instr_read(input addr_t a, output data_t rd);
      @(posedge clk_i);
      #2;
      i_req_i  = 1'b1;
      i_addr_i = a;
      do @(negedge clk_i); while (!i_ack_o);
      rd = i_rdata_o;
      @(posedge clk_i);
      #2;
      i_req_i = 1'b0;
      @(negedge clk_i);
      check("i_ack_o", 32'(i_ack_o), 32'd0);  // Single ack
   endtask

   task automatic data_access(input addr_t a, input data_t wd, input strb_t ws,
                              output data_t rd);
      @(posedge clk_i);
      #2;
      d_req_i   = 1'b1;
      d_addr_i  = a;
      d_wdata_i = wd;
      d_wstrb_i = ws;
      do @(negedge clk_i); while (!d_ack_o);
      rd = d_rdata_o;
      @(posedge clk_i);
      #2;
      d_req_i   = 1'b0;
      d_wstrb_i = '0;
      @(negedge clk_i);
      check("d_ack_o", 32'(d_ack_o), 32'd0);
   endtask

   task automatic pulse_inval();
      @(posedge clk_i);
      #2;
      inval_i = 1'b1;
      @(posedge clk_i);
      #2;
      inval_i = 1'b0;
   endtask

   task automatic run_instr();
      logic [31:0] r;
      addr_t       a;
      data_t       rd;
      int          cnt;
      for (int n = 0; n < N_OPS; n++) begin
         r = rand_bits(8);
         a = {1'b0, 6'b0, r[6:0], 2'b00};  // Read-only lower half
         instr_read(a, rd);
         check("i_rdata_o", rd, ref_mem[a[15:2]]);
         if (r[7]) begin
            cnt = rd_count[a[15:2]];
            instr_read(a, rd);
            check("i_rdata_o", rd, ref_mem[a[15:2]]);
            check("instr repeat mem reads", 32'(rd_count[a[15:2]]), 32'(cnt));
         end
      end
   endtask

   task automatic run_data();
      logic [31:0] r;
      addr_t       a;
      data_t       wd;
      data_t       rd;
      strb_t       ws;
      int          cnt;
      for (int n = 0; n < N_OPS; n++) begin
         r = rand_bits(10);
         a = {1'b1, 6'b0, r[6:0], 2'b00};  // Upper half
         case (r[9:7])
            3'd3, 3'd4, 3'd5: begin
               wd = rand_bits(32);
               ws = strb_t'(rand_bits(4));
               if (ws == '0) begin
                  ws = 4'hF;
               end
               data_access(a, wd, ws, rd);
               ref_mem[a[15:2]] = merge_bytes(ref_mem[a[15:2]], wd, ws);
               // Exactly one write went out before the ack
               check("mem write count", 32'(wr_addr_q.size()), 32'd1);
               check("mem_addr_o", 32'(wr_addr_q.pop_front()), 32'(a));
               check("mem_wdata_o", wr_data_q.pop_front(), wd);
               check("mem_wstrb_o", 32'(wr_strb_q.pop_front()), 32'(ws));
            end
            3'd6: begin
               data_access(a, '0, '0, rd);
               check("d_rdata_o", rd, ref_mem[a[15:2]]);
               cnt = rd_count[a[15:2]];
               data_access(a, '0, '0, rd);
               check("d_rdata_o", rd, ref_mem[a[15:2]]);
               check("data repeat mem reads", 32'(rd_count[a[15:2]]), 32'(cnt));
            end
            3'd7: begin
               data_access(a, '0, '0, rd);
               check("d_rdata_o", rd, ref_mem[a[15:2]]);
               cnt = rd_count[a[15:2]];
               pulse_inval();
               data_access(a, '0, '0, rd);
               check("d_rdata_o", rd, ref_mem[a[15:2]]);
               check("mem reads after inval", 32'(rd_count[a[15:2]]), 32'(cnt + 1));
            end
            default: begin
               data_access(a, '0, '0, rd);
               check("d_rdata_o", rd, ref_mem[a[15:2]]);
            end
         endcase
      end
   endtask

   // Memory responder with 0 to 3 cycles of delay
   initial begin
      addr_t       ra;
      data_t       rw;
      strb_t       rs;
      logic [31:0] dly;
      forever begin
         @(negedge clk_i);
         if (mem_req_o && !arst_i) begin
            ra  = mem_addr_o;
            rw  = mem_wdata_o;
            rs  = mem_wstrb_o;
            dly = rand_bits(2);
            repeat (dly) @(negedge clk_i);
            @(posedge clk_i);
            #2;
            if (rs == '0) begin
               mem_rdata_i = mem_q[ra[15:2]];
               rd_count[ra[15:2]]++;
            end else begin
               mem_q[ra[15:2]] = merge_bytes(mem_q[ra[15:2]], rw, rs);
               wr_addr_q.push_back(ra);
               wr_data_q.push_back(rw);
               wr_strb_q.push_back(rs);
            end
            mem_ack_i = 1'b1;
            @(posedge clk_i);
            #2;
            mem_ack_i   = 1'b0;
            mem_rdata_i = '0;
         end
      end
   end

   initial begin
      #(TIMEOUT);
      $display("Timeout: requests did not complete in time");
      $display("TESTBENCH FAILED");
      $fatal(1, "watchdog expired");
   end

   initial begin
      arst_i      = 1'b1;
      i_req_i     = 1'b0;
      i_addr_i    = '0;
      d_req_i     = 1'b0;
      d_addr_i    = '0;
      d_wdata_i   = '0;
      d_wstrb_i   = '0;
      inval_i     = 1'b0;
      mem_rdata_i = '0;
      mem_ack_i   = 1'b0;
      for (int w = 0; w < WORDS; w++) begin
         mem_q[w]    = rand_bits(32) ^ {w[15:0], w[15:0]};
         ref_mem[w]  = mem_q[w];
         rd_count[w] = 0;
      end
      repeat (10) @(posedge clk_i);
      #2;
      arst_i = 1'b0;
      fork
         run_instr();
         run_data();
      join
      repeat (4) @(posedge clk_i);
      // Protocol assertions in the bound checker
      check("assertion failures", 32'(ext_mem_i.u_sva.fail_cnt), 32'd0);
      $display("TESTBENCH PASSED");
      $finish;
   end

endmodule
